//--- bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

`define BUS_XLEN 32

// machine timer, low and high word
`define BUS_RTC_ADDR 32'h0200_bff8
`define BUS_RTC_ADDR_UP (`BUS_RTC_ADDR + 32'h4)

// instruction fetches inside this window go out as 2-beat bursts
`define BUS_IBURST_EN 1'b1
`define BUS_IBURST_LO 32'ha000_0000
`define BUS_IBURST_HI 32'hc000_0000

`define BUS_ID_LSU 4'h1
`define BUS_ID_IFU 4'h2

`endif

//--- bus_pkg.sv
`include "bus_params.svh"

package bus_pkg;

  typedef logic [`BUS_XLEN-1:0] addr_t;
  typedef logic [`BUS_XLEN-1:0] word_t;
  typedef logic [`BUS_XLEN/8-1:0] strb_t;
  typedef logic [3:0] axi_id_t;
  typedef logic [63:0] mtime_t;

  // cache side, requests are levels
  typedef struct packed {logic arvalid; addr_t araddr;} icache_req_t;
  typedef struct packed {logic bus_ready; logic rvalid; logic rlast; word_t rdata;} icache_rsp_t;
  typedef struct packed {logic arvalid; addr_t araddr; strb_t rstrb;} dcache_rd_req_t;
  typedef struct packed {logic rvalid; word_t rdata;} dcache_rd_rsp_t;
  typedef struct packed {
    logic awvalid;
    addr_t awaddr;
    logic wvalid;
    word_t wdata;
    strb_t wstrb;
  } dcache_wr_req_t;
  typedef struct packed {logic wready;} dcache_wr_rsp_t;  // done pulse

  // AXI4 channels
  typedef struct packed {
    logic valid;
    axi_id_t id;
    addr_t addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;
  typedef struct packed {logic valid; axi_id_t id; word_t data; logic [1:0] resp; logic last;} axi_r_t;
  typedef struct packed {logic valid; axi_id_t id; addr_t addr; logic [2:0] size;} axi_aw_t;
  typedef struct packed {logic valid; word_t data; strb_t strb; logic last;} axi_w_t;
  typedef struct packed {logic valid; axi_id_t id; logic [1:0] resp;} axi_b_t;

  typedef enum logic [2:0] {RD_IDLE, RD_IF_ADDR, RD_IF_DATA, RD_LS_ADDR, RD_LS_DATA} rd_state_t;
  typedef enum logic {WR_ADDR, WR_RESP} wr_state_t;

  // byte, half or word size from a low-aligned strobe
  function automatic logic [2:0] size_of_strb(strb_t strb);
    case (strb)
      4'h1: size_of_strb = 3'd0;
      4'h3: size_of_strb = 3'd1;
      default: size_of_strb = 3'd2;
    endcase
  endfunction

endpackage

//--- bus_read_port.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module bus_read_port
  import bus_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  icache_req_t    icache_req,
  input  dcache_rd_req_t dcache_rd_req,
  output icache_rsp_t    icache_rsp,
  output dcache_rd_rsp_t dcache_rd_rsp,
  output axi_ar_t        ar,
  input  logic           ar_ready,
  input  axi_r_t         r,
  output logic           r_ready,
  output logic           timer_hi,
  input  word_t          timer_rdata
);

  rd_state_t state;
  addr_t     addr_q;
  axi_id_t   id_q;
  logic      burst_q;

  logic is_timer;
  logic timer_hit;
  logic take_ls;
  logic take_if;
  logic if_burst;
  logic ar_done;
  logic r_done;

  // timer addresses are served locally, never by AXI
  assign is_timer = (dcache_rd_req.araddr == `BUS_RTC_ADDR) ||
                    (dcache_rd_req.araddr == `BUS_RTC_ADDR_UP);
  assign timer_hit = dcache_rd_req.arvalid && is_timer;
  assign timer_hi = dcache_rd_req.araddr == `BUS_RTC_ADDR_UP;

  // dcache wins the shared read channel
  assign take_ls = (state == RD_IDLE) && dcache_rd_req.arvalid && !is_timer;
  assign take_if = (state == RD_IDLE) && !take_ls && icache_req.arvalid;
  assign if_burst = `BUS_IBURST_EN && (icache_req.araddr >= `BUS_IBURST_LO) &&
                    (icache_req.araddr <= `BUS_IBURST_HI);

  assign ar_done = ar.valid && ar_ready;
  assign r_done = r.valid && r_ready && (!burst_q || r.last);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: begin
          if (take_ls) state <= RD_LS_ADDR;
          else if (take_if) state <= RD_IF_ADDR;
        end
        RD_IF_ADDR: if (ar_done) state <= RD_IF_DATA;
        RD_IF_DATA: if (r_done) state <= RD_IDLE;
        RD_LS_ADDR: if (ar_done) state <= RD_LS_DATA;
        RD_LS_DATA: if (r_done) state <= RD_IDLE;
        default: state <= RD_IDLE;
      endcase
    end
  end

  // captured once per request, held through the data phase
  always_ff @(posedge clock) begin
    if (take_ls) begin
      addr_q <= dcache_rd_req.araddr;
      id_q <= `BUS_ID_LSU;
      burst_q <= 1'b0;
    end else if (take_if) begin
      addr_q <= icache_req.araddr;
      id_q <= `BUS_ID_IFU;
      burst_q <= if_burst;
    end
  end

  assign ar.valid = (state == RD_IF_ADDR) || (state == RD_LS_ADDR);
  assign ar.id = id_q;
  assign ar.addr = addr_q;
  assign ar.len = {7'd0, burst_q};
  assign ar.size = (state == RD_LS_ADDR) ? size_of_strb(dcache_rd_req.rstrb) : 3'd2;
  assign ar.burst = burst_q ? 2'b01 : 2'b00;  // INCR only for fetch bursts

  assign r_ready = (state == RD_IF_DATA) || (state == RD_LS_DATA);

  assign icache_rsp.bus_ready = state == RD_IDLE;
  assign icache_rsp.rvalid = (state == RD_IF_DATA) && r.valid;
  assign icache_rsp.rlast = (state == RD_IF_DATA) && r.valid && (!burst_q || r.last);
  assign icache_rsp.rdata = r.data;

  assign dcache_rd_rsp.rvalid = ((state == RD_LS_DATA) && r.valid) || timer_hit;
  assign dcache_rd_rsp.rdata = timer_hit ? timer_rdata : r.data;

  // no error handling, slave must answer OKAY
  a_rresp_okay: assert property (
    @(posedge clock) disable iff (reset) r.valid && r_ready |-> r.resp == 2'b00
  );

  // dcache holds its load address, so a timer hit cannot overlap an AXI load
  a_timer_no_overlap: assert property (
    @(posedge clock) disable iff (reset) timer_hit |-> state != RD_LS_DATA
  );

endmodule

//--- bus_write_port.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module bus_write_port
  import bus_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  dcache_wr_req_t dcache_wr_req,
  output dcache_wr_rsp_t dcache_wr_rsp,
  output axi_aw_t        aw,
  input  logic           aw_ready,
  output axi_w_t         w,
  input  logic           w_ready,
  input  axi_b_t         b,
  output logic           b_ready
);

  wr_state_t state;
  logic      w_done;  // W beat already accepted for this store
  logic [1:0] offset;

  assign offset = dcache_wr_req.awaddr[1:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= WR_ADDR;
      w_done <= 1'b0;
    end else begin
      case (state)
        WR_ADDR: begin
          if (aw.valid && aw_ready) state <= WR_RESP;
          if (w.valid && w_ready) w_done <= 1'b1;
        end
        WR_RESP: begin
          if (b.valid) begin
            state <= WR_ADDR;
            w_done <= 1'b0;
          end else if (w.valid && w_ready) begin
            w_done <= 1'b1;
          end
        end
        default: state <= WR_ADDR;
      endcase
    end
  end

  assign aw.valid = (state == WR_ADDR) && dcache_wr_req.awvalid;
  assign aw.id = `BUS_ID_LSU;
  assign aw.addr = dcache_wr_req.awaddr;  // address stays unaligned
  assign aw.size = size_of_strb(dcache_wr_req.wstrb);

  // move data and strobe onto the byte lanes of the address
  assign w.valid = dcache_wr_req.wvalid && !w_done;
  assign w.data = dcache_wr_req.wdata << {offset, 3'b000};
  assign w.strb = dcache_wr_req.wstrb << offset;
  assign w.last = w.valid;  // single beat

  assign b_ready = state == WR_RESP;
  assign dcache_wr_rsp.wready = (state == WR_RESP) && b.valid;

  a_bresp_okay: assert property (
    @(posedge clock) disable iff (reset) b.valid |-> b.resp == 2'b00
  );

  // cache holds awvalid as a level until the address is taken
  a_aw_stable: assert property (
    @(posedge clock) disable iff (reset) aw.valid && !aw_ready |=> aw.valid
  );

endmodule

//--- clint_timer.sv
`timescale 1ns/100ps

module clint_timer
  import bus_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  timer_hi,
  output word_t rdata
);

  mtime_t mtime;

  // free running, one tick per clock
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  assign rdata = timer_hi ? mtime[63:32] : mtime[31:0];

endmodule

//--- cpu_bus.sv
`timescale 1ns/100ps

module cpu_bus
  import bus_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  icache_req_t    icache_req,
  input  dcache_rd_req_t dcache_rd_req,
  input  dcache_wr_req_t dcache_wr_req,
  output icache_rsp_t    icache_rsp,
  output dcache_rd_rsp_t dcache_rd_rsp,
  output dcache_wr_rsp_t dcache_wr_rsp,
  output axi_ar_t        ar,
  input  logic           ar_ready,
  input  axi_r_t         r,
  output logic           r_ready,
  output axi_aw_t        aw,
  input  logic           aw_ready,
  output axi_w_t         w,
  input  logic           w_ready,
  input  axi_b_t         b,
  output logic           b_ready
);

  logic  timer_hi;
  word_t timer_rdata;

  bus_read_port u_read_port (
    .clock        (clock),
    .reset        (reset),
    .icache_req   (icache_req),
    .dcache_rd_req(dcache_rd_req),
    .icache_rsp   (icache_rsp),
    .dcache_rd_rsp(dcache_rd_rsp),
    .ar           (ar),
    .ar_ready     (ar_ready),
    .r            (r),
    .r_ready      (r_ready),
    .timer_hi     (timer_hi),
    .timer_rdata  (timer_rdata)
  );

  bus_write_port u_write_port (
    .clock        (clock),
    .reset        (reset),
    .dcache_wr_req(dcache_wr_req),
    .dcache_wr_rsp(dcache_wr_rsp),
    .aw           (aw),
    .aw_ready     (aw_ready),
    .w            (w),
    .w_ready      (w_ready),
    .b            (b),
    .b_ready      (b_ready)
  );

  clint_timer u_clint (
    .clock   (clock),
    .reset   (reset),
    .timer_hi(timer_hi),
    .rdata   (timer_rdata)
  );

endmodule

//--- tb_axi_mem.sv
`timescale 1ns/100ps

module tb_axi_mem
  import bus_pkg::*;
#(
  parameter int SEED = 0
) (
  input  logic    clock,
  input  logic    reset,
  input  axi_ar_t ar,
  output logic    ar_ready,
  output axi_r_t  r,
  input  logic    r_ready,
  input  axi_aw_t aw,
  output logic    aw_ready,
  input  axi_w_t  w,
  output logic    w_ready,
  output axi_b_t  b,
  input  logic    b_ready
);

  word_t mem [addr_t];  // keyed by word-aligned address
  integer seed;
  logic ar_rnd, aw_rnd, w_rnd, r_rnd;
  logic rd_busy;
  addr_t rd_addr;
  logic [7:0] rd_len, rd_beat;
  axi_id_t rd_id, wr_id;
  logic aw_got, w_got;
  addr_t wr_addr;
  word_t wr_data, merged;
  strb_t wr_strb;

  initial seed = SEED;

  function automatic word_t fill_word(addr_t a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h3c5a_0f96;
  endfunction

  function automatic word_t read_word(addr_t a);
    if (mem.exists(a)) return mem[a];
    return fill_word(a);
  endfunction

  assign ar_ready = ar_rnd && !rd_busy;
  assign aw_ready = aw_rnd && !aw_got;
  assign w_ready = w_rnd && !w_got;

  always @(posedge clock) begin
    if (reset) begin
      {ar_rnd, aw_rnd, w_rnd, r_rnd} <= '0;
      {rd_busy, aw_got, w_got} <= '0;
      r <= '0;
      b <= '0;
    end else begin
      ar_rnd <= ($random(seed) & 3) != 0;  // ready about 3 cycles in 4
      aw_rnd <= ($random(seed) & 3) != 0;
      w_rnd <= ($random(seed) & 3) != 0;
      r_rnd <= ($random(seed) & 1) != 0;
      if (ar.valid && ar_ready) begin
        rd_busy <= 1'b1;
        rd_addr <= {ar.addr[31:2], 2'b00};
        rd_len <= ar.len;
        rd_beat <= 8'd0;
        rd_id <= ar.id;
      end
      if (rd_busy && !r.valid && r_rnd) begin
        r.valid <= 1'b1;
        r.id <= rd_id;
        r.data <= read_word(rd_addr + addr_t'({rd_beat, 2'b00}));
        r.resp <= 2'b00;
        r.last <= rd_beat == rd_len;
      end
      if (r.valid && r_ready) begin
        r.valid <= 1'b0;
        r.last <= 1'b0;
        rd_beat <= rd_beat + 8'd1;
        if (r.last) rd_busy <= 1'b0;
      end
      if (aw.valid && aw_ready) begin
        aw_got <= 1'b1;
        wr_addr <= {aw.addr[31:2], 2'b00};
        wr_id <= aw.id;
      end
      if (w.valid && w_ready) begin
        w_got <= 1'b1;
        wr_data <= w.data;
        wr_strb <= w.strb;
      end
      if (aw_got && w_got && !b.valid) begin
        merged = read_word(wr_addr);
        for (int i = 0; i < 4; i++) begin
          if (wr_strb[i]) merged[8*i +: 8] = wr_data[8*i +: 8];
        end
        mem[wr_addr] = merged;
        b.valid <= 1'b1;
        b.id <= wr_id;
        b.resp <= 2'b00;
      end
      if (b.valid && b_ready) begin
        b.valid <= 1'b0;
        aw_got <= 1'b0;
        w_got <= 1'b0;
      end
    end
  end

endmodule

//--- tb_cpu_bus.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module tb_cpu_bus
  import bus_pkg::*;
;

  localparam int CYCLE_LIMIT = 200 * 16 + 800;  // worst case per random op plus directed tests

  logic clock, reset;
  icache_req_t icache_req;
  dcache_rd_req_t dcache_rd_req;
  dcache_wr_req_t dcache_wr_req;
  icache_rsp_t icache_rsp;
  dcache_rd_rsp_t dcache_rd_rsp;
  dcache_wr_rsp_t dcache_wr_rsp;
  axi_ar_t ar;
  axi_r_t r;
  axi_aw_t aw;
  axi_w_t w;
  axi_b_t b;
  logic ar_ready, r_ready, aw_ready, w_ready, b_ready;

  word_t shadow [addr_t];
  mtime_t tcount;
  integer seed;
  int cycles, err_count, errs_at_start, tests_passed, tests_failed;
  int stores_done, loads_done, wr_pulses, rd_pulses;
  int fetch_beats, if_pulses;
  time ls_seen, if_seen;
  logic [31:0] rnd;
  addr_t addr;
  strb_t strb;
  logic [1:0] off;
  axi_ar_t ar_exp;
  axi_aw_t aw_exp;
  axi_w_t w_exp;

  cpu_bus u_cpu_bus (
    .clock(clock), .reset(reset),
    .icache_req(icache_req), .dcache_rd_req(dcache_rd_req), .dcache_wr_req(dcache_wr_req),
    .icache_rsp(icache_rsp), .dcache_rd_rsp(dcache_rd_rsp), .dcache_wr_rsp(dcache_wr_rsp),
    .ar(ar), .ar_ready(ar_ready), .r(r), .r_ready(r_ready),
    .aw(aw), .aw_ready(aw_ready), .w(w), .w_ready(w_ready), .b(b), .b_ready(b_ready)
  );

  tb_axi_mem #(.SEED(32'hb0a1_cae6)) u_mem (
    .clock(clock), .reset(reset), .ar(ar), .ar_ready(ar_ready), .r(r), .r_ready(r_ready),
    .aw(aw), .aw_ready(aw_ready), .w(w), .w_ready(w_ready), .b(b), .b_ready(b_ready)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // expected mtime starts at zero in the first cycle out of reset
  always @(posedge clock) begin
    if (reset) tcount <= '0;
    else tcount <= tcount + 64'd1;
  end

  always @(negedge clock) begin
    if (!reset && dcache_wr_rsp.wready) wr_pulses++;
    if (!reset && dcache_rd_rsp.rvalid) rd_pulses++;
    if (!reset && icache_rsp.rvalid) if_pulses++;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic word_t hash_word(addr_t a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h3c5a_0f96;
  endfunction

  function automatic word_t expect_word(addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    if (shadow.exists(wa)) return shadow[wa];
    return hash_word(wa);
  endfunction

  // bytes selected by the shifted strobe take the shifted data
  function automatic word_t merge_store(word_t old, word_t data, strb_t s, logic [1:0] o);
    word_t d, m;
    strb_t sh;
    d = data << (8 * o);
    sh = s << o;
    m = old;
    for (int i = 0; i < 4; i++) begin
      if (sh[i]) m[8*i +: 8] = d[8*i +: 8];
    end
    return m;
  endfunction

  function automatic logic in_burst_window(addr_t a);
    return (a >= `BUS_IBURST_LO) && (a <= `BUS_IBURST_HI);
  endfunction

  // byte, half and word strobes map to AXI sizes 0, 1 and 2
  function automatic logic [2:0] strb_size(strb_t s);
    case (s)
      4'h1: return 3'd0;
      4'h3: return 3'd1;
      4'hf: return 3'd2;
      default: return 3'd7;
    endcase
  endfunction

  task automatic report(input string line);
    $display("%s", line);
    err_count++;
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      report($sformatf("FAILED at %0t: %s data %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_time(input word_t got, input mtime_t exp, input logic hi);
    word_t half;
    half = hi ? exp[63:32] : exp[31:0];
    if (got !== half) begin
      report($sformatf("FAILED at %0t: timer word %h, expected %h", $time, got, half));
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) report($sformatf("FAILED at %0t: rlast %b, expected %b", $time, got, exp));
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report($sformatf("FAILED at %0t: %s %b, expected %b", $time, what, got, exp));
    end
  endtask

  // burst type only matters for a 2-beat fetch
  task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
    if (got.id !== exp.id || got.addr !== exp.addr || got.len !== exp.len ||
        got.size !== exp.size || (exp.len != 8'd0 && got.burst !== exp.burst)) begin
      report($sformatf("FAILED at %0t: AR %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_aw(input axi_aw_t got, input axi_aw_t exp);
    if (got !== exp) report($sformatf("FAILED at %0t: AW %h, expected %h", $time, got, exp));
  endtask

  task automatic check_w(input axi_w_t got, input axi_w_t exp);
    if (got !== exp) report($sformatf("FAILED at %0t: W %h, expected %h", $time, got, exp));
  endtask

  // AXI requests leaving the bridge against the cache request being held
  always @(negedge clock) begin
    if (!reset && ar.valid && ar_ready) begin
      ar_exp = '0;
      ar_exp.valid = 1'b1;
      if (dcache_rd_req.arvalid) begin  // a held load owns the AR channel
        ar_exp.id = `BUS_ID_LSU;
        ar_exp.addr = dcache_rd_req.araddr;
        ar_exp.size = strb_size(dcache_rd_req.rstrb);
      end else begin
        ar_exp.id = `BUS_ID_IFU;
        ar_exp.addr = icache_req.araddr;
        ar_exp.size = 3'd2;
        if (in_burst_window(icache_req.araddr)) begin
          ar_exp.len = 8'd1;
          ar_exp.burst = 2'b01;
        end
      end
      check_ar(ar, ar_exp);
    end
    if (!reset && aw.valid && aw_ready) begin
      aw_exp.valid = 1'b1;
      aw_exp.id = `BUS_ID_LSU;
      aw_exp.addr = dcache_wr_req.awaddr;
      aw_exp.size = strb_size(dcache_wr_req.wstrb);
      check_aw(aw, aw_exp);
    end
    if (!reset && w.valid && w_ready) begin
      w_exp.valid = 1'b1;
      w_exp.data = dcache_wr_req.wdata << (8 * dcache_wr_req.awaddr[1:0]);
      w_exp.strb = dcache_wr_req.wstrb << dcache_wr_req.awaddr[1:0];
      w_exp.last = 1'b1;
      check_w(w, w_exp);
    end
  end

  task automatic start_test();
    errs_at_start = err_count;
  endtask

  task automatic end_test(input string name);
    if (err_count == errs_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - errs_at_start);
    end
  endtask

  task automatic fetch(input addr_t a);
    int beat, nbeats;
    logic done;
    nbeats = in_burst_window(a) ? 2 : 1;
    beat = 0;
    done = 1'b0;
    @(posedge clock);
    icache_req <= '{arvalid: 1'b1, araddr: a};
    while (!done) begin
      @(negedge clock);
      if (icache_rsp.rvalid) begin
        if (beat == 0) if_seen = $time;
        check_word(icache_rsp.rdata, expect_word(a + addr_t'(4 * beat)), "fetch");
        check_last(icache_rsp.rlast, beat == nbeats - 1);
        check_level(icache_rsp.bus_ready, 1'b0, "bus_ready");
        if (icache_rsp.rlast || beat >= nbeats - 1) done = 1'b1;
        beat++;
      end
    end
    fetch_beats += nbeats;
    @(posedge clock);
    icache_req <= '0;
  endtask

  task automatic load(input addr_t a);
    @(posedge clock);
    dcache_rd_req <= '{arvalid: 1'b1, araddr: a, rstrb: 4'hf};
    do @(negedge clock); while (!dcache_rd_rsp.rvalid);
    ls_seen = $time;
    check_word(dcache_rd_rsp.rdata, expect_word(a), "load");
    loads_done++;
    @(posedge clock);
    dcache_rd_req <= '0;
  endtask

  task automatic timer_load(input logic hi);
    addr_t ta;
    ta = hi ? `BUS_RTC_ADDR_UP : `BUS_RTC_ADDR;
    @(posedge clock);
    dcache_rd_req <= '{arvalid: 1'b1, araddr: ta, rstrb: 4'hf};
    @(negedge clock);
    if (!dcache_rd_rsp.rvalid) report("timer load did not return rvalid in the same cycle");
    else check_time(dcache_rd_rsp.rdata, tcount, hi);
    loads_done++;
    @(posedge clock);
    dcache_rd_req <= '0;
  endtask

  task automatic store(input addr_t a, input word_t d, input strb_t s);
    @(posedge clock);
    dcache_wr_req <= '{awvalid: 1'b1, awaddr: a, wvalid: 1'b1, wdata: d, wstrb: s};
    do @(negedge clock); while (!dcache_wr_rsp.wready);
    @(posedge clock);
    dcache_wr_req <= '0;
    shadow[{a[31:2], 2'b00}] = merge_store(expect_word(a), d, s, a[1:0]);
    stores_done++;
  endtask

  task automatic check_counts();
    repeat (3) @(negedge clock);
    if (wr_pulses != stores_done) begin
      report($sformatf("%0d wready pulses for %0d stores", wr_pulses, stores_done));
    end
    if (rd_pulses != loads_done) begin
      report($sformatf("%0d dcache rvalid pulses for %0d loads", rd_pulses, loads_done));
    end
    if (if_pulses != fetch_beats) begin
      report($sformatf("%0d icache rvalid pulses for %0d fetch beats", if_pulses, fetch_beats));
    end
  endtask

  initial begin
    seed = 32'hb0a1_cae6;
    reset = 1'b1;
    icache_req = '0;
    dcache_rd_req = '0;
    dcache_wr_req = '0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    @(negedge clock);
    start_test();
    check_level(icache_rsp.bus_ready, 1'b1, "bus_ready");
    check_level(icache_rsp.rvalid, 1'b0, "icache rvalid");
    check_level(dcache_rd_rsp.rvalid, 1'b0, "dcache rvalid");
    check_level(dcache_wr_rsp.wready, 1'b0, "wready");
    check_level(ar.valid, 1'b0, "ar valid");
    check_level(aw.valid, 1'b0, "aw valid");
    check_level(w.valid, 1'b0, "w valid");
    check_level(r_ready, 1'b0, "r_ready");
    check_level(b_ready, 1'b0, "b_ready");
    end_test("reset");

    start_test();
    fetch(32'h8000_0040);
    end_test("single fetch");

    start_test();
    fetch(32'ha000_0010);
    end_test("burst fetch");

    start_test();
    fork
      load(32'h8000_0080);
      fetch(32'h8000_00c0);
    join
    if (ls_seen >= if_seen) report("read priority: icache was answered before dcache");
    end_test("read priority");

    start_test();
    for (int o = 0; o < 4; o++) begin
      store(32'h8000_0100 + addr_t'(o), $random(seed), 4'h1);
      load(32'h8000_0100);
    end
    store(32'h8000_0104, $random(seed), 4'h3);
    load(32'h8000_0104);
    store(32'h8000_0106, $random(seed), 4'h3);
    load(32'h8000_0104);
    store(32'h8000_0108, $random(seed), 4'hf);
    load(32'h8000_0108);
    check_counts();
    end_test("stores");

    start_test();
    timer_load(1'b0);
    timer_load(1'b1);
    end_test("timer");

    start_test();
    repeat (200) begin
      rnd = $random(seed);
      addr = 32'h8000_0100 + addr_t'({rnd[7:4], 2'b00});
      case (rnd[1:0])
        2'd0: load(addr);
        2'd1: begin
          case (rnd[9:8])
            2'd0: begin
              strb = 4'h1;
              off = rnd[11:10];
            end
            2'd1: begin
              strb = 4'h3;
              off = {rnd[10], 1'b0};
            end
            default: begin
              strb = 4'hf;
              off = 2'd0;
            end
          endcase
          store(addr + addr_t'(off), $random(seed), strb);
        end
        2'd2: fetch((rnd[12] ? 32'ha000_0000 : 32'h8000_0000) + addr_t'({rnd[7:4], 2'b00}));
        default: timer_load(rnd[13]);
      endcase
    end
    check_counts();
    end_test("back-pressure");

    $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) $display("TEST PASSED");
    else $display("TEST FAILED");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
bus_pkg.sv
bus_read_port.sv
bus_write_port.sv
clint_timer.sv
cpu_bus.sv
tb_axi_mem.sv
tb_cpu_bus.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module tb_cpu_bus \
  -Mdir obj_dir -o sim > build.log 2>&1 \
  && ./obj_dir/sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
! grep -q "TEST FAILED" sim.log \
  && grep -q "TEST PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
